// ==== vlog.f ====
+incdir+.
muldiv_pkg.sv
md_control.sv
md_multiplier.sv
md_divider.sv
md_hilo_regs.sv
muldiv.sv
tb_clock_gen.sv
tb_muldiv.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the muldiv testbench with Verilator, result taken from sim.log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --timescale 1ns/1ps -f vlog.f --top-module tb_muldiv \
    && ./obj_dir/Vtb_muldiv | tee sim.log \
    || { echo "Build or simulation did not complete"; exit 1; }

grep -q "Test completed successfully" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// ==== tb_muldiv.sv ====
`timescale 1ns/1ps
`include "muldiv_macros.svh"

module tb_muldiv;

    logic                clk;
    logic                arst_n;
    muldiv_pkg::md_op_t  md_op;
    muldiv_pkg::word_t   rs_in;
    muldiv_pkg::word_t   rt_in;
    muldiv_pkg::word_t   res_out;
    logic                md_stall;

    // Bookkeeping
    muldiv_pkg::word_t   lcg_state;
    muldiv_pkg::word_t   res;
    int                  cycles;
    int                  errors;
    int                  timeouts;

    tb_clock_gen i_clock_gen (.clk(clk), .arst_n(arst_n));

    muldiv i_dut (.clk(clk), .arst_n(arst_n), .md_op(md_op), .rs_in(rs_in),
                  .rt_in(rt_in), .res_out(res_out), .md_stall(md_stall));

    ////////////////////
    // Helpers
    ////////////////////
    // Numerical Recipes LCG constants
    function automatic muldiv_pkg::word_t next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic report_mismatch(input string test, input muldiv_pkg::word_t exp,
                                   input muldiv_pkg::word_t act);
        errors++;
        $display("ERROR [%s] expected %h, actual %h", test, exp, act);
    endtask

    // Present one op at posedge+1, wait for retirement, capture result and latency
    task automatic issue(input muldiv_pkg::md_op_t op, input muldiv_pkg::word_t a,
                         input muldiv_pkg::word_t b);
        md_op  = op;
        rs_in  = a;
        rt_in  = b;
        cycles = 0;
        // Stall and result are settled by the falling edge
        do begin
            @(negedge clk);
            cycles++;
        end while (md_stall && cycles < 100);
        if (md_stall) begin
            timeouts++;
            $display("Timeout: op %0d still stalled after 100 cycles", op);
        end
        res = res_out;
        // Ride through the retire edge and park the bus on NOP
        @(posedge clk);
        #1;
        md_op = `MD_OP_NOP;
    endtask

    // Read back HI and LO through MFHI and MFLO
    task automatic check_hilo(input string test, input muldiv_pkg::word_t exp_hi,
                              input muldiv_pkg::word_t exp_lo);
        issue(`MD_OP_MFHI, '0, '0);
        if (res !== exp_hi)
            report_mismatch({test, " hi"}, exp_hi, res);
        if (cycles != 1)
            report_mismatch({test, " mfhi cycles"}, 1, cycles);
        issue(`MD_OP_MFLO, '0, '0);
        if (res !== exp_lo)
            report_mismatch({test, " lo"}, exp_lo, res);
        if (cycles != 1)
            report_mismatch({test, " mflo cycles"}, 1, cycles);
    endtask

    ////////////////////
    // Reference model
    ////////////////////
    // Low 64 bits of the extended product are exact for both modes
    function automatic muldiv_pkg::dword_t mul_model(input logic sgn,
                                                     input muldiv_pkg::word_t a,
                                                     input muldiv_pkg::word_t b);
        muldiv_pkg::dword_t ax;
        muldiv_pkg::dword_t bx;
        ax = sgn ? {{32{a[31]}}, a} : {32'd0, a};
        bx = sgn ? {{32{b[31]}}, b} : {32'd0, b};
        return ax * bx;
    endfunction

    // Magnitude division then sign rules
    // Zero divisor gives all ones
    task automatic div_model(input logic sgn, input muldiv_pkg::word_t a,
                             input muldiv_pkg::word_t b, output muldiv_pkg::word_t q,
                             output muldiv_pkg::word_t r);
        muldiv_pkg::word_t am;
        muldiv_pkg::word_t bm;
        muldiv_pkg::word_t qm;
        muldiv_pkg::word_t rm;
        am = (sgn && a[31]) ? -a : a;
        bm = (sgn && b[31]) ? -b : b;
        qm = (bm == 0) ? '1 : am / bm;
        rm = (bm == 0) ? am : am % bm;
        q  = (sgn && (a[31] ^ b[31])) ? -qm : qm;
        r  = (sgn && a[31]) ? -rm : rm;
    endtask

    task automatic run_mult(input muldiv_pkg::md_op_t op, input muldiv_pkg::word_t a,
                            input muldiv_pkg::word_t b, input string test);
        muldiv_pkg::dword_t exp;
        issue(op, a, b);
        if (cycles != 2)
            report_mismatch({test, " cycles"}, 2, cycles);
        exp = mul_model(op == `MD_OP_MULT, a, b);
        check_hilo(test, exp[63:32], exp[31:0]);
    endtask

    task automatic run_div(input muldiv_pkg::md_op_t op, input muldiv_pkg::word_t a,
                           input muldiv_pkg::word_t b, input string test);
        muldiv_pkg::word_t q;
        muldiv_pkg::word_t r;
        issue(op, a, b);
        // Load, 32 steps, retire
        if (cycles != 34)
            report_mismatch({test, " cycles"}, 34, cycles);
        div_model(op == `MD_OP_DIV, a, b, q, r);
        check_hilo(test, r, q);
    endtask

    ////////////////////
    // Tests
    ////////////////////
    task automatic test_move();
        check_hilo("move_reset", '0, '0);
        issue(`MD_OP_MTHI, 32'hdead_beef, '0);
        if (cycles != 1)
            report_mismatch("move mthi cycles", 1, cycles);
        issue(`MD_OP_MTLO, 32'h1234_5678, '0);
        if (cycles != 1)
            report_mismatch("move mtlo cycles", 1, cycles);
        check_hilo("move", 32'hdead_beef, 32'h1234_5678);
    endtask

    task automatic test_mult();
        muldiv_pkg::word_t a;
        muldiv_pkg::word_t b;
        run_mult(`MD_OP_MULT, 32'h8000_0000, 32'h8000_0000, "mult min*min");
        run_mult(`MD_OP_MULT, 32'hffff_ffff, 32'h7fff_ffff, "mult -1*max");
        run_mult(`MD_OP_MULTU, 32'hffff_ffff, 32'hffff_ffff, "multu max*max");
        run_mult(`MD_OP_MULTU, 32'h0, 32'h1234_5678, "multu zero");
        for (int i = 0; i < 20; i++) begin
            a = next_rand();
            b = next_rand();
            run_mult(`MD_OP_MULT, a, b, "mult rand");
            run_mult(`MD_OP_MULTU, a, b, "multu rand");
        end
    endtask

    task automatic test_mul();
        muldiv_pkg::dword_t exp;
        issue(`MD_OP_MTHI, 32'h0bad_cafe, '0);
        issue(`MD_OP_MTLO, 32'h600d_f00d, '0);
        issue(`MD_OP_MUL, 32'hffff_fff3, 32'h0000_0007);
        exp = mul_model(1'b1, 32'hffff_fff3, 32'h0000_0007);
        if (res !== exp[31:0])
            report_mismatch("mul", exp[31:0], res);
        if (cycles != 2)
            report_mismatch("mul cycles", 2, cycles);
        // HI and LO must be untouched by MUL
        check_hilo("mul keep", 32'h0bad_cafe, 32'h600d_f00d);
    endtask

    task automatic test_div();
        run_div(`MD_OP_DIV, -32'sd7, 32'd2, "div -7/2");
        run_div(`MD_OP_DIV, 32'd7, -32'sd2, "div 7/-2");
        run_div(`MD_OP_DIV, -32'sd7, -32'sd2, "div -7/-2");
        run_div(`MD_OP_DIV, 32'h8000_0000, 32'hffff_ffff, "div min/-1");
        run_div(`MD_OP_DIV, 32'h8000_0000, 32'd3, "div min/3");
        run_div(`MD_OP_DIVU, 32'hffff_ffff, 32'd3, "divu max/3");
        for (int i = 0; i < 20; i++) begin
            run_div(i[0] ? `MD_OP_DIVU : `MD_OP_DIV, next_rand(), next_rand() >> (i % 24),
                    "div rand");
        end
    endtask

    // Zero divisor, signed and unsigned
    task automatic test_div_zero();
        issue(`MD_OP_DIV, -32'sd5, '0);
        check_hilo("div_zero neg", -32'sd5, 32'd1);
        issue(`MD_OP_DIV, 32'd12345, '0);
        check_hilo("div_zero pos", 32'd12345, 32'hffff_ffff);
        issue(`MD_OP_DIVU, 32'hdead_beef, '0);
        check_hilo("div_zero divu", 32'hdead_beef, 32'hffff_ffff);
    endtask

    task automatic test_back_to_back();
        muldiv_pkg::dword_t exp;
        muldiv_pkg::word_t  q;
        muldiv_pkg::word_t  r;
        // No gap between the two issues
        issue(`MD_OP_MULT, 32'd1000, 32'd3000);
        if (cycles != 2)
            report_mismatch("b2b mult first cycles", 2, cycles);
        issue(`MD_OP_MULT, 32'hffff_fffe, 32'h4000_0001);
        if (cycles != 2)
            report_mismatch("b2b mult second cycles", 2, cycles);
        exp = mul_model(1'b1, 32'hffff_fffe, 32'h4000_0001);
        check_hilo("b2b mult", exp[63:32], exp[31:0]);
        issue(`MD_OP_DIV, 32'd100, 32'd7);
        if (cycles != 34)
            report_mismatch("b2b div first cycles", 34, cycles);
        issue(`MD_OP_DIV, -32'sd1000, 32'd33);
        if (cycles != 34)
            report_mismatch("b2b div second cycles", 34, cycles);
        div_model(1'b1, -32'sd1000, 32'd33, q, r);
        check_hilo("b2b div", r, q);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        md_op     = `MD_OP_NOP;
        rs_in     = '0;
        rt_in     = '0;
        res       = '0;
        cycles    = 0;
        errors    = 0;
        timeouts  = 0;
        lcg_state = 32'h6bce_b9ff;
        for (int n = 0; n < 20 && !arst_n; n++) begin
            @(posedge clk);
        end
        if (!arst_n) begin
            timeouts++;
            $display("Timeout: reset was never released");
        end
        @(posedge clk);
        #1;
        test_move();
        test_mult();
        test_mul();
        test_div();
        test_div_zero();
        test_back_to_back();
        $display("Summary: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    // 100 ns period, first rising edge at 50 ns
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset low for 8 rising edges, released just after the last one
    initial begin
        arst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
    end

endmodule

// ==== muldiv.sv ====
`timescale 1ns/1ps

module muldiv (
    input  logic                clk,
    input  logic                arst_n,
    input  muldiv_pkg::md_op_t  md_op,
    input  muldiv_pkg::word_t   rs_in,
    input  muldiv_pkg::word_t   rt_in,
    output muldiv_pkg::word_t   res_out,
    output logic                md_stall
);

    // Sequencer strobes
    logic                mul_start;
    logic                div_start;
    logic                is_signed;
    logic                mt_hi;
    logic                mt_lo;
    logic                mult_we;
    logic                div_done;

    // Datapath
    muldiv_pkg::dword_t  product;
    muldiv_pkg::word_t   quotient;
    muldiv_pkg::word_t   remainder;
    muldiv_pkg::word_t   hi;
    muldiv_pkg::word_t   lo;

    ////////////////////
    // Control
    ////////////////////
    md_control i_control (
        .clk       (clk),
        .arst_n    (arst_n),
        .md_op     (md_op),
        .div_done  (div_done),
        .product   (product),
        .hi        (hi),
        .lo        (lo),
        .mul_start (mul_start),
        .div_start (div_start),
        .is_signed (is_signed),
        .mt_hi     (mt_hi),
        .mt_lo     (mt_lo),
        .mult_we   (mult_we),
        .md_stall  (md_stall),
        .res_out   (res_out)
    );

    ////////////////////
    // Arithmetic
    ////////////////////
    md_multiplier i_multiplier (
        .clk       (clk),
        .arst_n    (arst_n),
        .mul_start (mul_start),
        .is_signed (is_signed),
        .rs_in     (rs_in),
        .rt_in     (rt_in),
        .product   (product)
    );

    // rs is the dividend, rt the divisor
    md_divider i_divider (
        .clk       (clk),
        .arst_n    (arst_n),
        .div_start (div_start),
        .is_signed (is_signed),
        .dividend  (rs_in),
        .divisor   (rt_in),
        .quotient  (quotient),
        .remainder (remainder),
        .div_done  (div_done)
    );

    ////////////////////
    // HI/LO
    ////////////////////
    md_hilo_regs i_hilo_regs (
        .clk       (clk),
        .arst_n    (arst_n),
        .mt_hi     (mt_hi),
        .mt_lo     (mt_lo),
        .mult_we   (mult_we),
        .div_we    (div_done),
        .rs_in     (rs_in),
        .product   (product),
        .quotient  (quotient),
        .remainder (remainder),
        .hi        (hi),
        .lo        (lo)
    );

endmodule

// ==== md_hilo_regs.sv ====
`timescale 1ns/1ps

module md_hilo_regs (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                mt_hi,
    input  logic                mt_lo,
    input  logic                mult_we,
    input  logic                div_we,
    input  muldiv_pkg::word_t   rs_in,
    input  muldiv_pkg::dword_t  product,
    input  muldiv_pkg::word_t   quotient,
    input  muldiv_pkg::word_t   remainder,
    output muldiv_pkg::word_t   hi,
    output muldiv_pkg::word_t   lo
);

    localparam int W = $bits(muldiv_pkg::word_t);

    ////////////////////
    // HI register
    ////////////////////
    // Sources never overlap, order is just for readability
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hi <= '0;
        end else if (mt_hi) begin
            hi <= rs_in;
        end else if (mult_we) begin
            // Upper product half
            hi <= product[2*W-1:W];
        end else if (div_we) begin
            // Remainder goes to HI
            hi <= remainder;
        end
    end

    ////////////////////
    // LO register
    ////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lo <= '0;
        end else if (mt_lo) begin
            lo <= rs_in;
        end else if (mult_we) begin
            lo <= product[W-1:0];
        end else if (div_we) begin
            // Quotient to LO
            lo <= quotient;
        end
    end

endmodule

// ==== md_divider.sv ====
`timescale 1ns/1ps
`include "muldiv_macros.svh"

module md_divider (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               div_start,
    input  logic               is_signed,
    input  muldiv_pkg::word_t  dividend,
    input  muldiv_pkg::word_t  divisor,
    output muldiv_pkg::word_t  quotient,
    output muldiv_pkg::word_t  remainder,
    output logic               div_done
);

    localparam int W = $bits(muldiv_pkg::word_t);

    muldiv_pkg::div_state_t  state;
    muldiv_pkg::step_cnt_t   step_cnt;
    logic                    neg_quo;
    logic                    neg_rem;

    // Working registers, magnitudes only
    muldiv_pkg::word_t       rem_q;
    muldiv_pkg::word_t       quo_q;
    muldiv_pkg::word_t       dvs_q;

    muldiv_pkg::word_t       dividend_mag;
    muldiv_pkg::word_t       divisor_mag;
    muldiv_pkg::word_t       src_rem;
    muldiv_pkg::word_t       src_quo;
    muldiv_pkg::word_t       src_dvs;
    logic [W:0]              rem_shift;
    logic [W:0]              rem_diff;
    logic                    fits;
    muldiv_pkg::word_t       rem_next;
    muldiv_pkg::word_t       quo_next;
    logic                    step_en;

    ////////////////////
    // Magnitudes
    ////////////////////
    assign dividend_mag = (is_signed && dividend[W-1]) ? -dividend : dividend;
    assign divisor_mag  = (is_signed && divisor[W-1])  ? -divisor  : divisor;

    ////////////////////
    // Restoring step
    ////////////////////
    // Load cycle feeds the fresh operands, first quotient bit falls out there
    assign src_rem = (state == muldiv_pkg::div_idle) ? '0           : rem_q;
    assign src_quo = (state == muldiv_pkg::div_idle) ? dividend_mag : quo_q;
    assign src_dvs = (state == muldiv_pkg::div_idle) ? divisor_mag  : dvs_q;

    // Shift next dividend bit into the partial remainder
    assign rem_shift = {src_rem, src_quo[W-1]};
    assign fits      = (rem_shift >= {1'b0, src_dvs});
    assign rem_diff  = rem_shift - {1'b0, src_dvs};
    // Restore on no fit; zero divisor always fits, leaves dividend as remainder
    assign rem_next  = fits ? rem_diff[W-1:0] : rem_shift[W-1:0];
    assign quo_next  = {src_quo[W-2:0], fits};

    assign step_en = ((state == muldiv_pkg::div_idle) && div_start) ||
                     (state == muldiv_pkg::div_run);

    ////////////////////
    // Divider FSM
    ////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= muldiv_pkg::div_idle;
            step_cnt <= '0;
            neg_quo  <= 1'b0;
            neg_rem  <= 1'b0;
        end else begin
            case (state)
                muldiv_pkg::div_idle: begin
                    if (div_start) begin
                        // Quotient negative on sign mismatch, remainder follows dividend
                        neg_quo  <= is_signed && (dividend[W-1] ^ divisor[W-1]);
                        neg_rem  <= is_signed && dividend[W-1];
                        step_cnt <= muldiv_pkg::step_cnt_t'(1);
                        state    <= muldiv_pkg::div_run;
                    end
                end
                muldiv_pkg::div_run: begin
                    step_cnt <= step_cnt + 1'b1;
                    // Last step runs on this edge
                    if (step_cnt == muldiv_pkg::step_cnt_t'(`MD_DIV_STEPS - 1)) begin
                        state <= muldiv_pkg::div_fin;
                    end
                end
                muldiv_pkg::div_fin: state <= muldiv_pkg::div_idle;
                default:             state <= muldiv_pkg::div_idle;
            endcase
        end
    end

    // Datapath registers
    always_ff @(posedge clk) begin
        if (step_en) begin
            rem_q <= rem_next;
            quo_q <= quo_next;
        end
        if ((state == muldiv_pkg::div_idle) && div_start) begin
            dvs_q <= divisor_mag;
        end
    end

    ////////////////////
    // Sign correction
    ////////////////////
    // Valid while div_done is high
    assign quotient  = neg_quo ? -quo_q : quo_q;
    assign remainder = neg_rem ? -rem_q : rem_q;
    assign div_done  = (state == muldiv_pkg::div_fin);

endmodule

// ==== md_multiplier.sv ====
`timescale 1ns/1ps

module md_multiplier (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                mul_start,
    input  logic                is_signed,
    input  muldiv_pkg::word_t   rs_in,
    input  muldiv_pkg::word_t   rt_in,
    output muldiv_pkg::dword_t  product
);

    localparam int W = $bits(muldiv_pkg::word_t);

    logic              rs_sign;
    logic              rt_sign;
    logic [2*W-1:0]    rs_ext;
    logic [2*W-1:0]    rt_ext;
    logic [2*W-1:0]    full_product;

    ////////////////////
    // Operand extension
    ////////////////////
    // Sign fill only for signed ops
    assign rs_sign = is_signed & rs_in[W-1];
    assign rt_sign = is_signed & rt_in[W-1];

    // Widened to the product width so both modes share one multiplier
    assign rs_ext = {{W{rs_sign}}, rs_in};
    assign rt_ext = {{W{rt_sign}}, rt_in};

    // Product modulo 2^64 is exact for either mode
    assign full_product = rs_ext * rt_ext;

    ////////////////////
    // Product register
    ////////////////////
    // Captured on the first cycle of a multiply
    // Held afterwards so MUL can read it at retire
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            product <= '0;
        end else if (mul_start) begin
            product <= full_product;
        end
    end

endmodule

// ==== md_control.sv ====
`timescale 1ns/1ps
`include "muldiv_macros.svh"

module md_control (
    input  logic                clk,
    input  logic                arst_n,
    input  muldiv_pkg::md_op_t  md_op,
    input  logic                div_done,
    input  muldiv_pkg::dword_t  product,
    input  muldiv_pkg::word_t   hi,
    input  muldiv_pkg::word_t   lo,
    output logic                mul_start,
    output logic                div_start,
    output logic                is_signed,
    output logic                mt_hi,
    output logic                mt_lo,
    output logic                mult_we,
    output logic                md_stall,
    output muldiv_pkg::word_t   res_out
);

    logic                     is_mul;
    logic                     is_div;
    logic                     is_mult_hl;
    muldiv_pkg::ctrl_state_t  state_q;
    muldiv_pkg::ctrl_state_t  state_cur;
    muldiv_pkg::ctrl_state_t  state_nxt;

    ////////////////////
    // Decode
    ////////////////////
    assign is_div     = (md_op == `MD_OP_DIV) || (md_op == `MD_OP_DIVU);
    // Multiplies that write HI/LO
    assign is_mult_hl = (md_op == `MD_OP_MULT) || (md_op == `MD_OP_MULTU);
    assign is_mul     = is_mult_hl || (md_op == `MD_OP_MUL);
    // MUL counts as signed, same as MULT
    assign is_signed  = (md_op == `MD_OP_DIV) || (md_op == `MD_OP_MUL) ||
                        (md_op == `MD_OP_MULT);
    assign mt_hi      = (md_op == `MD_OP_MTHI);
    assign mt_lo      = (md_op == `MD_OP_MTLO);

    ////////////////////
    // Sequencer
    ////////////////////
    // Entry decode: in idle the new op picks its wait state this same cycle
    always_comb begin
        state_cur = state_q;
        if (state_q == muldiv_pkg::ctrl_idle) begin
            if (is_mul) begin
                state_cur = muldiv_pkg::ctrl_mul_wait;
            end else if (is_div) begin
                state_cur = muldiv_pkg::ctrl_div_wait;
            end
        end
    end

    // Start pulses only on the first cycle of an op
    assign mul_start = (state_q == muldiv_pkg::ctrl_idle) && is_mul;
    assign div_start = (state_q == muldiv_pkg::ctrl_idle) && is_div;

    always_comb begin
        state_nxt = state_cur;
        case (state_cur)
            muldiv_pkg::ctrl_idle:     state_nxt = muldiv_pkg::ctrl_idle;
            // Product lands at the end of the first cycle
            muldiv_pkg::ctrl_mul_wait: state_nxt = muldiv_pkg::ctrl_done;
            muldiv_pkg::ctrl_div_wait: begin
                if (div_done) begin
                    state_nxt = muldiv_pkg::ctrl_done;
                end
            end
            // Retire edge, next op enters from idle
            muldiv_pkg::ctrl_done:     state_nxt = muldiv_pkg::ctrl_idle;
            default:                   state_nxt = muldiv_pkg::ctrl_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= muldiv_pkg::ctrl_idle;
            mult_we <= 1'b0;
        end else begin
            state_q <= state_nxt;
            // Launched at the product edge, HI/LO take it from the product register
            mult_we <= mul_start && is_mult_hl;
        end
    end

    // Hold the pipeline until the retire cycle
    assign md_stall = (is_mul || is_div) && (state_cur != muldiv_pkg::ctrl_done);

    ////////////////////
    // Result mux
    ////////////////////
    always_comb begin
        case (md_op)
            `MD_OP_MFHI: res_out = hi;
            `MD_OP_MFLO: res_out = lo;
            `MD_OP_MUL:  res_out = product[`MD_WIDTH-1:0];
            default:     res_out = '0;
        endcase
    end

endmodule

// ==== muldiv_pkg.sv ====
`include "muldiv_macros.svh"

package muldiv_pkg;

    ////////////////////
    // Data types
    ////////////////////
    // Operand, HI, LO and result word
    typedef logic [`MD_WIDTH-1:0] word_t;

    // Full multiplier product, HI in the upper half
    typedef logic [2*`MD_WIDTH-1:0] dword_t;

    // Operation code as issued by the pipeline
    typedef logic [3:0] md_op_t;

    // Divider step counter, wide enough to hold MD_DIV_STEPS itself
    typedef logic [$clog2(`MD_DIV_STEPS):0] step_cnt_t;

    ////////////////////
    // State machines
    ////////////////////
    // Sequencer states
    typedef enum logic [1:0] {
        ctrl_idle     = 2'd0,
        ctrl_mul_wait = 2'd1,
        ctrl_div_wait = 2'd2,
        ctrl_done     = 2'd3
    } ctrl_state_t;

    // Divider states
    typedef enum logic [1:0] {
        div_idle = 2'd0,
        div_run  = 2'd1,
        div_fin  = 2'd2
    } div_state_t;

endpackage

// ==== muldiv_macros.svh ====
`ifndef MULDIV_MACROS_SVH
`define MULDIV_MACROS_SVH

// Datapath width of operands, HI, LO and result
`define MD_WIDTH       32

// Restoring divider iterations, one quotient bit each
`define MD_DIV_STEPS   32

////////////////////
// Operation codes
////////////////////
// Zero means no operation on this cycle
`define MD_OP_NOP      4'd0
`define MD_OP_DIV      4'd1
`define MD_OP_DIVU     4'd2
`define MD_OP_MFHI     4'd3
`define MD_OP_MFLO     4'd4
`define MD_OP_MTHI     4'd5
`define MD_OP_MTLO     4'd6
// MUL returns low word only, MULT/MULTU fill HI and LO
`define MD_OP_MUL      4'd7
`define MD_OP_MULT     4'd8
`define MD_OP_MULTU    4'd9

`endif
